// File: logic/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address split into tag, index and byte offset
`define TAG_WIDTH       20
`define INDEX_WIDTH     8
`define OFFSET_WIDTH    4

// line geometry
`define LINE_WIDTH      128
`define WORDS_PER_LINE  4
`define SET_COUNT       256

// memory read type codes on the rd channel
`define RD_TYPE_WORD    3'b010
`define RD_TYPE_LINE    3'b100

`endif

// File: logic/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    // address fields
    typedef logic [`TAG_WIDTH-1:0]      tag_t;
    typedef logic [`INDEX_WIDTH-1:0]    index_t;
    typedef logic [`OFFSET_WIDTH-1:0]   offset_t;

    // word number inside a line
    typedef logic [`OFFSET_WIDTH-3:0]   word_sel_t;

    typedef logic [31:0]                word_t;
    typedef logic [`LINE_WIDTH-1:0]     line_t;

    // two ways only
    typedef logic                       way_t;
    typedef logic [1:0]                 hit_vec_t;

    typedef enum logic [1:0] {
        op_read        = 2'd0,
        op_inval_index = 2'd1,
        op_inval_hit   = 2'd2
    } cache_op_e;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_lookup = 2'd1,
        st_miss   = 2'd2,
        st_refill = 2'd3
    } main_state_e;

    // core request held with valid until addr_ok
    typedef struct packed {
        cache_op_e op;
        tag_t      tag;
        index_t    index;
        offset_t   offset;
        logic      uncached;
    } core_req_s;

    typedef struct packed {
        logic        req;
        logic [2:0]  rd_type;
        logic [31:0] addr;
    } mem_rd_s;

    // one returned beat
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } mem_ret_s;

endpackage

`default_nettype wire

// File: logic/icache_tag_store.sv
`default_nettype none

`include "icache_settings.svh"

module icache_tag_store
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     rd_en,
    input  index_t   rd_index,
    input  tag_t     cmp_tag,
    input  logic     wr_en,
    input  logic     inval_en,
    input  way_t     way,
    input  index_t   wr_index,
    input  tag_t     wr_tag,
    output hit_vec_t hit
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t                  tags [`SET_COUNT];
        logic [`SET_COUNT-1:0] valids;
        tag_t                  pre_tag;
        logic                  pre_valid;
        logic                  way_sel;

        assign way_sel = (way == way_t'(w));

        // tag array and tag preload
        always_ff @(posedge clk) begin
            if (wr_en && way_sel) begin
                tags[wr_index] <= wr_tag;
            end
            if (rd_en) begin
                pre_tag <= tags[rd_index];
            end
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valids    <= '0;
                pre_valid <= 1'b0;
            end else begin
                // refill sets and invalidate clears
                if (wr_en && way_sel) begin
                    valids[wr_index] <= 1'b1;
                end else if (inval_en && way_sel) begin
                    valids[wr_index] <= 1'b0;
                end
                if (rd_en) begin
                    pre_valid <= valids[rd_index];
                end
            end
        end

        // compare against the tag latched by the controller
        assign hit[w] = pre_valid && (pre_tag == cmp_tag);
    end

    // a line is never filled into both ways
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!resetn)
        !(hit[0] && hit[1])
    );

endmodule

`default_nettype wire

// File: logic/icache_data_store.sv
`default_nettype none

`include "icache_settings.svh"

module icache_data_store
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rd_en,
    input  index_t    rd_index,
    input  word_sel_t word_sel,
    input  hit_vec_t  hit,
    input  logic      wr_en,
    input  way_t      wr_way,
    input  index_t    wr_index,
    input  line_t     wr_line,
    output word_t     word
);

    line_t rd_line [2];
    line_t sel_line;

    // one line RAM per way with registered read
    for (genvar w = 0; w < 2; w++) begin : g_way
        line_t ram [`SET_COUNT];

        always_ff @(posedge clk) begin
            if (wr_en && wr_way == way_t'(w)) begin
                ram[wr_index] <= wr_line;
            end
            if (rd_en) begin
                rd_line[w] <= ram[rd_index];
            end
        end
    end

    // way 0 when nothing hits
    always_comb begin
        if (hit[1]) begin
            sel_line = rd_line[1];
        end else begin
            sel_line = rd_line[0];
        end
    end

    assign word = sel_line[{word_sel, 5'd0} +: 32];

endmodule

`default_nettype wire

// File: logic/icache_refill_buffer.sv
`default_nettype none

`include "icache_settings.svh"

module icache_refill_buffer
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  mem_ret_s  ret,
    input  word_sel_t word_sel,
    output line_t     line,
    output word_t     word
);

    // one extra bit so a full burst can be seen
    logic [`OFFSET_WIDTH-2:0] beat_cnt;
    line_t                    line_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
        end else if (ret.valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            line_q <= '0;
        end else if (ret.valid) begin
            line_q <= line;
        end
    end

    // current beat merged in so the last beat is usable in its own cycle
    always_comb begin
        line = line_q;
        if (ret.valid) begin
            line[{beat_cnt[`OFFSET_WIDTH-3:0], 5'd0} +: 32] = ret.data;
        end
    end

    assign word = line[{word_sel, 5'd0} +: 32];

    // memory must end a line burst after four beats
    a_no_extra_beat: assert property (
        @(posedge clk) disable iff (!resetn)
        ret.valid |-> (beat_cnt < `WORDS_PER_LINE)
    );

endmodule

`default_nettype wire

// File: logic/icache_ctrl.sv
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  core_req_s req,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    output mem_rd_s   mem_rd,
    input  logic      rd_rdy,
    input  mem_ret_s  ret,
    input  hit_vec_t  hit,
    input  word_t     hit_word,
    input  word_t     fill_word,
    output logic      lookup_en,
    output index_t    lookup_index,
    output tag_t      lookup_tag,
    output word_sel_t word_sel,
    output logic      fill_start,
    output logic      fill_wr,
    output logic      inval,
    output way_t      way
);

    main_state_e state_q;
    main_state_e state_d;
    core_req_s   req_q;
    way_t        victim_q;
    logic        in_lookup;
    logic        is_read;
    logic        is_hit;
    logic        hit_done;
    logic        burst_done;

    // requests are taken only when idle
    assign addr_ok   = valid && (state_q == st_idle);
    assign in_lookup = (state_q == st_lookup);
    assign is_read   = (req_q.op == op_read);
    assign is_hit    = |hit;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= req;
        end
    end

    // arrays read with the incoming index and written with the latched one
    assign lookup_en    = addr_ok;
    assign lookup_index = addr_ok ? req.index : req_q.index;
    assign lookup_tag   = req_q.tag;
    assign word_sel     = req_q.offset[`OFFSET_WIDTH-1:2];

    assign hit_done   = in_lookup && is_read && !req_q.uncached && is_hit;
    assign burst_done = (state_q == st_refill) && ret.valid && ret.last;

    // miss or uncached read goes to memory
    assign fill_start = in_lookup && is_read && !hit_done;
    assign fill_wr    = burst_done && !req_q.uncached;

    assign inval = in_lookup &&
                   ((req_q.op == op_inval_index) || (req_q.op == op_inval_hit && is_hit));

    always_comb begin
        way = victim_q;
        if (in_lookup) begin
            if (req_q.op == op_inval_index) begin
                way = req_q.offset[0];
            end else if (req_q.op == op_inval_hit) begin
                way = hit[1];
            end
        end
    end

    assign data_ok = hit_done || burst_done;

    always_comb begin
        if (in_lookup) begin
            rdata = hit_word;
        end else if (req_q.uncached) begin
            rdata = ret.data;
        end else begin
            rdata = fill_word;
        end
    end

    // request held until rd_rdy moves us to refill
    always_comb begin
        mem_rd.req = (state_q == st_miss);
        if (req_q.uncached) begin
            mem_rd.rd_type = `RD_TYPE_WORD;
            mem_rd.addr    = {req_q.tag, req_q.index, req_q.offset};
        end else begin
            mem_rd.rd_type = `RD_TYPE_LINE;
            mem_rd.addr    = {req_q.tag, req_q.index, {`OFFSET_WIDTH{1'b0}}};
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (addr_ok) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                state_d = fill_start ? st_miss : st_idle;
            end
            st_miss: begin
                if (rd_rdy) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                if (burst_done) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q  <= st_idle;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // one round robin pointer shared by all sets
            if (fill_wr) begin
                victim_q <= ~victim_q;
            end
        end
    end

    // data_ok never comes in st_idle and only ends a read
    a_no_data_ok_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        data_ok |-> ((state_q != st_idle) && is_read)
    );

    a_rd_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (mem_rd.req && !rd_rdy) |=> (mem_rd.req && $stable(mem_rd))
    );

endmodule

`default_nettype wire

// File: logic/icache_top.sv
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  core_req_s req,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,
    output mem_rd_s   mem_rd,
    input  logic      rd_rdy,
    input  mem_ret_s  ret
);

    hit_vec_t  hit;
    word_t     hit_word;
    word_t     fill_word;
    line_t     fill_line;
    logic      lookup_en;
    index_t    lookup_index;
    tag_t      lookup_tag;
    word_sel_t word_sel;
    logic      fill_start;
    logic      fill_wr;
    logic      inval;
    way_t      way;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .req          (req),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .mem_rd       (mem_rd),
        .rd_rdy       (rd_rdy),
        .ret          (ret),
        .hit          (hit),
        .hit_word     (hit_word),
        .fill_word    (fill_word),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .fill_start   (fill_start),
        .fill_wr      (fill_wr),
        .inval        (inval),
        .way          (way)
    );

    // lookup_index carries the latched index outside the accept cycle
    icache_tag_store u_tag (
        .clk      (clk),
        .resetn   (resetn),
        .rd_en    (lookup_en),
        .rd_index (lookup_index),
        .cmp_tag  (lookup_tag),
        .wr_en    (fill_wr),
        .inval_en (inval),
        .way      (way),
        .wr_index (lookup_index),
        .wr_tag   (lookup_tag),
        .hit      (hit)
    );

    icache_data_store u_data (
        .clk      (clk),
        .rd_en    (lookup_en),
        .rd_index (lookup_index),
        .word_sel (word_sel),
        .hit      (hit),
        .wr_en    (fill_wr),
        .wr_way   (way),
        .wr_index (lookup_index),
        .wr_line  (fill_line),
        .word     (hit_word)
    );

    icache_refill_buffer u_fill (
        .clk      (clk),
        .resetn   (resetn),
        .start    (fill_start),
        .ret      (ret),
        .word_sel (word_sel),
        .line     (fill_line),
        .word     (fill_word)
    );

endmodule

`default_nettype wire

// File: testbench/icache_mem_model.sv
`default_nettype none

`include "icache_settings.svh"

module icache_mem_model
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  mem_rd_s  mem_rd,
    output logic     rd_rdy,
    output mem_ret_s ret
);

    localparam int DRIVE_DELAY = 10;

    // fibonacci lfsr with taps 8 6 5 4
    logic [7:0] lfsr_q = 8'd73;

    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
        lfsr_q = {lfsr_q[6:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    // memory contents follow the byte address
    function automatic word_t mem_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    initial begin
        mem_rd_s cmd;
        int      beats;
        rd_rdy = 1'b0;
        ret    = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (resetn && mem_rd.req) begin
                cmd = mem_rd;
                // 0 to 3 cycles before accepting
                repeat (rand_bits(2)) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                end
                rd_rdy = 1'b1;
                @(posedge clk);
                #DRIVE_DELAY;
                rd_rdy = 1'b0;
                beats  = (cmd.rd_type == `RD_TYPE_LINE) ? `WORDS_PER_LINE : 1;
                for (int i = 0; i < beats; i++) begin
                    repeat (rand_bits(1)) begin
                        @(posedge clk);
                        #DRIVE_DELAY;
                    end
                    ret.valid = 1'b1;
                    ret.last  = (i == beats - 1);
                    ret.data  = mem_word(cmd.addr + 32'(i * 4));
                    @(posedge clk);
                    #DRIVE_DELAY;
                    ret = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/icache_tb.sv
`default_nettype none

`include "icache_settings.svh"

module icache_tb
    import icache_pkg::*;
;

    localparam int CYCLE       = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int ROW_CYCLES  = 40;

    typedef struct packed {
        core_req_s req;
        logic      mem;
        word_t     word;
    } row_s;

    logic      clk = 1'b0;
    logic      resetn;
    logic      valid;
    core_req_s req;
    logic      addr_ok;
    logic      data_ok;
    word_t     rdata;
    mem_rd_s   mem_rd;
    logic      rd_rdy;
    mem_ret_s  ret;

    row_s      rows [$];
    bit        table_ready = 1'b0;
    int        rd_rises = 0;
    logic      req_seen = 1'b0;
    mem_rd_s   last_rd;

    // reference tag state with one victim pointer for all sets
    logic      model_valid [2][`SET_COUNT];
    tag_t      model_tag [2][`SET_COUNT];
    logic      model_victim = 1'b0;

    always #(CYCLE / 2) clk = ~clk;

    icache_top uut (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .req     (req),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .mem_rd  (mem_rd),
        .rd_rdy  (rd_rdy),
        .ret     (ret)
    );

    icache_mem_model u_mem (
        .clk    (clk),
        .resetn (resetn),
        .mem_rd (mem_rd),
        .rd_rdy (rd_rdy),
        .ret    (ret)
    );

    // count memory requests at the port
    always @(negedge clk) begin
        if (mem_rd.req && !req_seen) begin
            rd_rises = rd_rises + 1;
            last_rd  = mem_rd;
        end
        req_seen = mem_rd.req;
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic add_row(input cache_op_e op, input tag_t tag, input index_t index,
                           input offset_t offset, input logic uncached,
                           input logic mem, input word_t word);
        row_s r;
        r.req.op       = op;
        r.req.tag      = tag;
        r.req.index    = index;
        r.req.offset   = offset;
        r.req.uncached = uncached;
        r.mem          = mem;
        r.word         = word;
        rows.push_back(r);
    endtask

    // returns whether the access should reach memory
    function automatic logic model_access(input core_req_s r);
        logic hit0;
        logic hit1;
        logic to_mem;
        hit0   = model_valid[0][r.index] && (model_tag[0][r.index] == r.tag);
        hit1   = model_valid[1][r.index] && (model_tag[1][r.index] == r.tag);
        to_mem = 1'b0;
        case (r.op)
            op_read: begin
                to_mem = r.uncached || !(hit0 || hit1);
                if (!r.uncached && !(hit0 || hit1)) begin
                    model_valid[model_victim][r.index] = 1'b1;
                    model_tag[model_victim][r.index]   = r.tag;
                    model_victim = ~model_victim;
                end
            end
            op_inval_index: begin
                model_valid[r.offset[0]][r.index] = 1'b0;
            end
            op_inval_hit: begin
                if (hit0) begin
                    model_valid[0][r.index] = 1'b0;
                end
                if (hit1) begin
                    model_valid[1][r.index] = 1'b0;
                end
            end
            default: begin
            end
        endcase
        return to_mem;
    endfunction

    task automatic build_table();
        // op, tag, index, offset, uncached, from memory, word
        add_row(op_read,        20'h12345, 8'h10, 4'h4, 1'b0, 1'b1, 32'hB791_5104);
        add_row(op_read,        20'h12345, 8'h10, 4'hC, 1'b0, 1'b0, 32'hB791_510C);
        add_row(op_read,        20'h00001, 8'h20, 4'h8, 1'b1, 1'b1, 32'hA5A5_1208);
        add_row(op_read,        20'h00001, 8'h20, 4'h8, 1'b0, 1'b1, 32'hA5A5_1208);
        add_row(op_read,        20'h00001, 8'h20, 4'h0, 1'b0, 1'b0, 32'hA5A5_1200);
        // three tags in set 0x30
        add_row(op_read,        20'h00002, 8'h30, 4'h0, 1'b0, 1'b1, 32'hA5A5_2300);
        add_row(op_read,        20'h00003, 8'h30, 4'h4, 1'b0, 1'b1, 32'hA5A5_3304);
        add_row(op_read,        20'h00004, 8'h30, 4'h8, 1'b0, 1'b1, 32'hA5A5_4308);
        add_row(op_read,        20'h00003, 8'h30, 4'h4, 1'b0, 1'b0, 32'hA5A5_3304);
        add_row(op_read,        20'h00002, 8'h30, 4'h0, 1'b0, 1'b1, 32'hA5A5_2300);
        add_row(op_inval_index, 20'h00000, 8'h10, 4'h0, 1'b0, 1'b0, 32'h0);
        add_row(op_read,        20'h12345, 8'h10, 4'h4, 1'b0, 1'b1, 32'hB791_5104);
        // invalidate on hit with the wrong tag first
        add_row(op_inval_hit,   20'h00009, 8'h20, 4'h0, 1'b0, 1'b0, 32'h0);
        add_row(op_read,        20'h00001, 8'h20, 4'h4, 1'b0, 1'b0, 32'hA5A5_1204);
        add_row(op_inval_hit,   20'h00001, 8'h20, 4'h0, 1'b0, 1'b0, 32'h0);
        add_row(op_read,        20'h00001, 8'h20, 4'hC, 1'b0, 1'b1, 32'hA5A5_120C);
        add_row(op_read,        20'h00001, 8'h20, 4'h0, 1'b0, 1'b0, 32'hA5A5_1200);
        add_row(op_inval_index, 20'h00000, 8'h30, 4'h1, 1'b0, 1'b0, 32'h0);
        add_row(op_read,        20'h00004, 8'h30, 4'h8, 1'b0, 1'b0, 32'hA5A5_4308);
    endtask

    task automatic run_row(input row_s row);
        int         rises_before;
        int         wait_cycles;
        logic       model_mem;
        logic [2:0] exp_type;
        word_t      exp_addr;
        model_mem = model_access(row.req);
        check_equal(64'(model_mem), 64'(row.mem), "table disagrees with tag model");
        @(posedge clk);
        #DRIVE_DELAY;
        valid = 1'b1;
        req   = row.req;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        rises_before = rd_rises;
        @(posedge clk);
        #DRIVE_DELAY;
        valid = 1'b0;
        if (row.req.op == op_read) begin
            wait_cycles = 1;
            @(negedge clk);
            while (!data_ok) begin
                wait_cycles = wait_cycles + 1;
                @(negedge clk);
            end
            check_equal(64'(rdata), 64'(row.word), "read data");
            check_equal(64'(rd_rises - rises_before), 64'(row.mem), "memory request count");
            if (row.mem) begin
                exp_type = row.req.uncached ? `RD_TYPE_WORD : `RD_TYPE_LINE;
                exp_addr = {row.req.tag, row.req.index,
                            row.req.uncached ? row.req.offset : 4'h0};
                check_equal(64'(last_rd.rd_type), 64'(exp_type), "memory read type");
                check_equal(64'(last_rd.addr), 64'(exp_addr), "memory read address");
            end else begin
                check_equal(64'(wait_cycles), 64'd1, "hit latency");
            end
        end else begin
            // lookup cycle and then back to idle
            repeat (2) begin
                @(negedge clk);
                check_equal(64'(data_ok), 64'd0, "data_ok on maintenance op");
            end
        end
    endtask

    initial begin
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `SET_COUNT; s++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s]   = '0;
            end
        end
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("All tests passed!");
        $finish;
    end

    // worst case per row covers rdy delay, four beats and gaps
    initial begin
        wait (table_ready);
        #((rows.size() * ROW_CYCLES + 10) * CYCLE);
        $display("Timeout: the cache did not finish all table rows in the allowed time");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_refill_buffer.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= icache_tb
RTL_TOP    ?= icache_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing
SIM_FLAGS  ?= --binary --timing --assert

FAIL_MSG := Test failures found
PASS_MSG := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
